/* src/lsqPkg.sv */
`default_nettype none

package lsqPkg;

  // fixed by the core
  localparam int numSlots = 6;
  localparam int numInstr = 10;
  localparam int lineAddrWidth = 14;
  // low sixteen banks form the low half, high sixteen the high half
  localparam int bankCount = 32;
  localparam int storeDataWidth = 64;

  // write index value for an unused store port
  localparam logic [2:0] noStore = 3'd7;

  // address descriptor of one memory operation
  typedef struct packed {
    logic [lineAddrWidth-1:0] evenAddr;
    logic [lineAddrWidth-1:0] oddAddr;
    logic [bankCount-1:0] banks;
    logic evenLow;
    logic evenHigh;
    logic oddLow;
    logic oddHigh;
    logic valid;
    logic isStore;
  } lsAddrT;

  // per-slot retire information
  typedef struct packed {
    logic [3:0] instrIdx;
    logic except;
    logic [3:0] exBits;
    logic waitConfl;
    logic [storeDataWidth-1:0] storeData;
  } slotInfoT;

  typedef struct packed {
    lsAddrT [numSlots-1:0] addrs;
    slotInfoT [numSlots-1:0] slots;
    logic [2:0] wrInd0;
    logic [2:0] wrInd1;
    logic [2:0] wrInd2;
    // one-hot
    logic [2:0] rotPos;
  } bundleT;

  // one bit per instruction slot of the retire window
  typedef struct packed {
    logic [numInstr-1:0] enable;
    logic [numInstr-1:0] fine;
    logic [numInstr-1:0] ldConfl;
    logic [numInstr-1:0] waitConfl;
    logic [numInstr-1:0] except;
    logic [4*numInstr-1:0] exBits;
  } retireT;

  typedef enum logic [1:0] {
    idle,
    holding,
    flushed
  } retireStateT;

endpackage

`default_nettype wire

/* src/lsqConflictPair.sv */
`timescale 1ns/1ps
`default_nettype none

module lsqConflictPair (
  input  lsqPkg::lsAddrT a,
  input  lsqPkg::lsAddrT b,
  output logic confl
);
  import lsqPkg::*;

  logic matchEven;
  logic matchOdd;
  logic bankLow;
  logic bankHigh;
  logic oddHighHit;
  logic oddLowHit;
  logic evenHighHit;
  logic evenLowHit;

  assign matchEven = (a.evenAddr == b.evenAddr);
  assign matchOdd = (a.oddAddr == b.oddAddr);

  // any common byte bank in each half
  assign bankLow = |(a.banks[bankCount/2-1:0] & b.banks[bankCount/2-1:0]);
  assign bankHigh = |(a.banks[bankCount-1:bankCount/2] & b.banks[bankCount-1:bankCount/2]);

  assign oddHighHit = a.oddHigh && b.oddHigh && matchOdd && bankHigh;
  assign oddLowHit = a.oddLow && b.oddLow && matchOdd && bankLow;
  assign evenHighHit = a.evenHigh && b.evenHigh && matchEven && bankHigh;
  assign evenLowHit = a.evenLow && b.evenLow && matchEven && bankLow;

  // only live operations can collide
  assign confl = a.valid && b.valid &&
                 (oddHighHit || oddLowHit || evenHighHit || evenLowHit);

endmodule

`default_nettype wire

/* src/lsqConflictBundle.sv */
`timescale 1ns/1ps
`default_nettype none

module lsqConflictBundle (
  input  lsqPkg::lsAddrT [lsqPkg::numSlots-1:0] addrs,
  output logic [lsqPkg::numSlots-1:0] ldConfl
);
  import lsqPkg::*;

  // pairConfl[h][k] is set when slot h overlaps earlier slot k
  logic [numSlots-1:0] pairConfl [1:numSlots-1];

  // slot 0 has nothing before it
  assign ldConfl[0] = 1'b0;

  for (genvar h = 1; h < numSlots; h++) begin : genLater
    for (genvar k = 0; k < numSlots; k++) begin : genEarlier
      if (k < h) begin : genPair
        lsqConflictPair pairCheck (
          .a(addrs[h]),
          .b(addrs[k]),
          .confl(pairConfl[h][k])
        );
      end else begin : genNone
        // same or later slot, never charged to h
        assign pairConfl[h][k] = 1'b0;
      end
    end
    assign ldConfl[h] = |pairConfl[h];
  end

endmodule

`default_nettype wire

/* src/storeWriteSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module storeWriteSelect (
  input  lsqPkg::slotInfoT [lsqPkg::numSlots-1:0] slots,
  input  logic [2:0] wrInd0,
  input  logic [2:0] wrInd1,
  input  logic [2:0] wrInd2,
  input  logic [2:0] rotPos,
  output logic [lsqPkg::storeDataWidth-1:0] wrData0,
  output logic [lsqPkg::storeDataWidth-1:0] wrData1,
  output logic [lsqPkg::storeDataWidth-1:0] wrData2,
  output logic wrEn0,
  output logic wrEn1,
  output logic wrEn2
);
  import lsqPkg::*;

  logic [2:0] wrInd [3];
  logic [storeDataWidth-1:0] pickData [3];
  logic pickEn [3];
  logic [storeDataWidth-1:0] portData [3];
  logic portEn [3];

  assign wrInd[0] = wrInd0;
  assign wrInd[1] = wrInd1;
  assign wrInd[2] = wrInd2;

  // slot pick per index, noStore or out of range gives zero
  always_comb begin
    for (int p = 0; p < 3; p++) begin
      pickData[p] = '0;
      pickEn[p] = 1'b0;
      for (int s = 0; s < numSlots; s++) begin
        if (wrInd[p] == 3'(s)) begin
          pickData[p] = slots[s].storeData;
          pickEn[p] = 1'b1;
        end
      end
    end
  end

  // rotate picks onto the write ports
  always_comb begin
    int src;
    for (int o = 0; o < 3; o++) begin
      if (rotPos[1]) begin
        src = (o + 2) % 3;
      end else if (rotPos[2]) begin
        src = (o + 1) % 3;
      end else begin
        src = o;
      end
      portData[o] = pickData[src];
      portEn[o] = pickEn[src];
    end
  end

  assign wrData0 = portData[0];
  assign wrData1 = portData[1];
  assign wrData2 = portData[2];
  assign wrEn0 = portEn[0];
  assign wrEn1 = portEn[1];
  assign wrEn2 = portEn[2];

endmodule

`default_nettype wire

/* src/lsqRetireDecide.sv */
`timescale 1ns/1ps
`default_nettype none

module lsqRetireDecide (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  lsqPkg::bundleT bundle,
  input  logic [lsqPkg::numSlots-1:0] ldConfl,
  input  logic bundleValid,
  output logic bundleReady,
  input  logic resultAck,
  output logic resultValid,
  output lsqPkg::retireT retire,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData0,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData1,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData2,
  output logic storeWrEn0,
  output logic storeWrEn1,
  output logic storeWrEn2
);
  import lsqPkg::*;

  retireStateT state;
  bundleT held;
  logic [numSlots-1:0] heldConfl;
  logic accept;
  logic [numSlots-1:0] live;
  logic [2:0] portInd0;
  logic [2:0] portInd1;
  logic [2:0] portInd2;

  assign resultValid = (state == holding);

  // room when nothing is held or the held result leaves this cycle
  assign bundleReady = !flush && (!resultValid || resultAck);
  assign accept = bundleValid && bundleReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else if (flush) begin
      state <= flushed;
    end else if (accept) begin
      state <= holding;
    end else if ((resultValid && resultAck) || state == flushed) begin
      state <= idle;
    end
  end

  // bundle payload and its conflict mask
  always_ff @(posedge clk) begin
    if (accept) begin
      held <= bundle;
      heldConfl <= ldConfl;
    end
  end

  // slots that count toward the retire window
  always_comb begin
    for (int s = 0; s < numSlots; s++) begin
      live[s] = resultValid && held.addrs[s].valid;
    end
  end

  always_comb begin
    logic hit;
    retire = '0;
    for (int k = 0; k < numInstr; k++) begin
      for (int s = 0; s < numSlots; s++) begin
        hit = live[s] && (held.slots[s].instrIdx == 4'(k));
        retire.enable[k] |= hit;
        retire.except[k] |= hit && held.slots[s].except;
        retire.ldConfl[k] |= hit && heldConfl[s];
        retire.waitConfl[k] |= hit && held.slots[s].waitConfl;
        retire.exBits[4*k +: 4] |= held.slots[s].exBits & {4{hit}};
      end
      // retires cleanly only with no flag on any mapped slot
      retire.fine[k] = retire.enable[k] && !retire.except[k] &&
                       !retire.ldConfl[k] && !retire.waitConfl[k];
    end
  end

  // idle ports while no result is held
  assign portInd0 = resultValid ? held.wrInd0 : noStore;
  assign portInd1 = resultValid ? held.wrInd1 : noStore;
  assign portInd2 = resultValid ? held.wrInd2 : noStore;

  storeWriteSelect storeSelect (
    .slots(held.slots),
    .wrInd0(portInd0),
    .wrInd1(portInd1),
    .wrInd2(portInd2),
    .rotPos(held.rotPos),
    .wrData0(storeWrData0),
    .wrData1(storeWrData1),
    .wrData2(storeWrData2),
    .wrEn0(storeWrEn0),
    .wrEn1(storeWrEn1),
    .wrEn2(storeWrEn2)
  );

endmodule

`default_nettype wire

/* src/lsqCheckTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lsqCheckTop (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic bundleValid,
  input  lsqPkg::bundleT bundle,
  output logic bundleReady,
  output logic resultValid,
  output lsqPkg::retireT retire,
  input  logic resultAck,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData0,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData1,
  output logic [lsqPkg::storeDataWidth-1:0] storeWrData2,
  output logic storeWrEn0,
  output logic storeWrEn1,
  output logic storeWrEn2
);
  import lsqPkg::*;

  // per slot, set when an earlier slot overlaps
  logic [numSlots-1:0] ldConfl;

  lsqConflictBundle conflictCheck (
    .addrs(bundle.addrs),
    .ldConfl(ldConfl)
  );

  lsqRetireDecide retireDecide (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .bundle(bundle),
    .ldConfl(ldConfl),
    .bundleValid(bundleValid),
    .bundleReady(bundleReady),
    .resultAck(resultAck),
    .resultValid(resultValid),
    .retire(retire),
    .storeWrData0(storeWrData0),
    .storeWrData1(storeWrData1),
    .storeWrData2(storeWrData2),
    .storeWrEn0(storeWrEn0),
    .storeWrEn1(storeWrEn1),
    .storeWrEn2(storeWrEn2)
  );

endmodule

`default_nettype wire

/* testbench/lsqCheckTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsqCheckTb;
  import lsqPkg::*;

  localparam int clkPeriod = 40;
  localparam int numRandom = 200;
  // conflict pairs, store routing, random, flush and the bundle after it
  localparam int numBundles = 16 + 21 + numRandom + 2;
  localparam int watchdogCycles = numBundles * 10 + 16 + 20;

  typedef struct packed {
    retireT retire;
    logic [2:0][storeDataWidth-1:0] wrData;
    logic [2:0] wrEn;
  } expT;

  logic clk;
  logic rst;
  logic flush;
  logic bundleValid;
  bundleT bundle;
  logic bundleReady;
  logic resultValid;
  retireT retire;
  logic resultAck;
  logic [storeDataWidth-1:0] storeWrData0;
  logic [storeDataWidth-1:0] storeWrData1;
  logic [storeDataWidth-1:0] storeWrData2;
  logic storeWrEn0;
  logic storeWrEn1;
  logic storeWrEn2;

  expT expQ [$];
  string testName = "reset";
  int mismatchCount = 0;
  int otherCount = 0;
  int checkedCount = 0;
  logic [31:0] rngState = 32'haccb;
  // 0 ack held high, 1 random stretches, 2 ack held low
  int ackMode = 0;
  int ackLeft = 0;
  logic ackRand = 1'b1;
  logic randFlush = 1'b0;

  lsqCheckTop dut_i (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .bundleValid(bundleValid),
    .bundle(bundle),
    .bundleReady(bundleReady),
    .resultValid(resultValid),
    .retire(retire),
    .resultAck(resultAck),
    .storeWrData0(storeWrData0),
    .storeWrData1(storeWrData1),
    .storeWrData2(storeWrData2),
    .storeWrEn0(storeWrEn0),
    .storeWrEn1(storeWrEn1),
    .storeWrEn2(storeWrEn2)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // 0..5 pick a slot, 6 stands for an unused port
  function automatic logic [2:0] storeInd(int v);
    return (v == 6) ? noStore : 3'(v);
  endfunction

  function automatic bundleT randBundle();
    bundleT b;
    for (int s = 0; s < numSlots; s++) begin
      // few distinct lines so that overlaps are common
      b.addrs[s].evenAddr = 14'(nextRand() % 3);
      b.addrs[s].oddAddr = 14'(nextRand() % 3);
      b.addrs[s].banks = nextRand() & nextRand();
      b.addrs[s].evenLow = nextRand() % 2;
      b.addrs[s].evenHigh = nextRand() % 2;
      b.addrs[s].oddLow = nextRand() % 2;
      b.addrs[s].oddHigh = nextRand() % 2;
      b.addrs[s].valid = (nextRand() % 4) != 0;
      b.addrs[s].isStore = nextRand() % 2;
      b.slots[s].instrIdx = 4'(nextRand() % 10);
      b.slots[s].except = (nextRand() % 8) == 0;
      b.slots[s].exBits = 4'(nextRand());
      b.slots[s].waitConfl = (nextRand() % 8) == 0;
      b.slots[s].storeData = {nextRand(), nextRand()};
    end
    b.wrInd0 = storeInd(nextRand() % 7);
    b.wrInd1 = storeInd(nextRand() % 7);
    b.wrInd2 = storeInd(nextRand() % 7);
    b.rotPos = 3'(1 << (nextRand() % 3));
    return b;
  endfunction

  // same line half, same line address, common bank in that half
  function automatic logic overlaps(lsAddrT x, lsAddrT y);
    logic lowHit;
    logic highHit;
    logic evenEq;
    logic oddEq;
    lowHit = (x.banks[15:0] & y.banks[15:0]) != 16'h0;
    highHit = (x.banks[31:16] & y.banks[31:16]) != 16'h0;
    evenEq = x.evenAddr == y.evenAddr;
    oddEq = x.oddAddr == y.oddAddr;
    return x.valid && y.valid &&
           ((x.oddHigh && y.oddHigh && oddEq && highHit) ||
            (x.oddLow && y.oddLow && oddEq && lowHit) ||
            (x.evenHigh && y.evenHigh && evenEq && highHit) ||
            (x.evenLow && y.evenLow && evenEq && lowHit));
  endfunction

  function automatic expT refModel(bundleT b);
    expT e;
    logic [numSlots-1:0] confl;
    logic [2:0] ind [3];
    logic [storeDataWidth-1:0] pickData [3];
    logic pickEn [3];
    int order [3];
    int k;
    e = '0;
    confl = '0;
    for (int h = 1; h < numSlots; h++) begin
      for (int j = 0; j < h; j++) begin
        confl[h] |= overlaps(b.addrs[h], b.addrs[j]);
      end
    end
    for (int s = 0; s < numSlots; s++) begin
      k = b.slots[s].instrIdx;
      if (b.addrs[s].valid && k < numInstr) begin
        e.retire.enable[k] = 1'b1;
        e.retire.except[k] |= b.slots[s].except;
        e.retire.ldConfl[k] |= confl[s];
        e.retire.waitConfl[k] |= b.slots[s].waitConfl;
        e.retire.exBits[4*k +: 4] |= b.slots[s].exBits;
      end
    end
    e.retire.fine = e.retire.enable &
                    ~(e.retire.except | e.retire.ldConfl | e.retire.waitConfl);
    ind = '{b.wrInd0, b.wrInd1, b.wrInd2};
    for (int p = 0; p < 3; p++) begin
      pickEn[p] = ind[p] < numSlots;
      pickData[p] = '0;
      if (pickEn[p]) begin
        pickData[p] = b.slots[ind[p]].storeData;
      end
    end
    // which pick lands on ports 0, 1 and 2
    case (b.rotPos)
      3'b010: order = '{2, 0, 1};
      3'b100: order = '{1, 2, 0};
      default: order = '{0, 1, 2};
    endcase
    for (int o = 0; o < 3; o++) begin
      e.wrData[o] = pickData[order[o]];
      e.wrEn[o] = pickEn[order[o]];
    end
    return e;
  endfunction

  task automatic compareField(input string field, input logic [255:0] expVal,
                              input logic [255:0] actVal);
    assert (actVal === expVal) else begin
      mismatchCount++;
      $display("mismatch %s %s: expected %h actual %h", testName, field, expVal, actVal);
    end
  endtask

  // expected results follow every accepted bundle
  always @(posedge clk) begin : compareResults
    expT e;
    logic expReady;
    if (rst) begin
      expQ.delete();
    end else begin
      // room when nothing is pending or the pending result is taken now
      expReady = !flush && (expQ.size() == 0 || resultAck);
      compareField("bundleReady", expReady, bundleReady);
      assert (resultValid == (expQ.size() != 0)) else begin
        otherCount++;
        $display("%s: resultValid is %b while %0d results are pending",
                 testName, resultValid, expQ.size());
      end
      if (resultValid && expQ.size() != 0) begin
        e = expQ[0];
        compareField("retire", e.retire, retire);
        compareField("store ports", {e.wrData, e.wrEn},
                     {storeWrData2, storeWrData1, storeWrData0,
                      storeWrEn2, storeWrEn1, storeWrEn0});
        if (flush || resultAck) begin
          void'(expQ.pop_front());
          checkedCount++;
        end
      end
      if (bundleValid && expReady) begin
        expQ.push_back(refModel(bundle));
      end
    end
  end

  task automatic driveControls();
    if (ackLeft == 0) begin
      ackLeft = nextRand() % 5 + 1;
      ackRand = nextRand() % 2;
    end
    ackLeft--;
    resultAck = (ackMode == 0) || (ackMode == 1 && ackRand);
    flush = randFlush && (nextRand() % 16 == 0);
  endtask

  task automatic idle();
    @(negedge clk);
    driveControls();
    bundleValid = 1'b0;
  endtask

  task automatic sendBundle(input bundleT b);
    @(negedge clk);
    driveControls();
    bundle = b;
    bundleValid = 1'b1;
    @(posedge clk);
    while (!bundleReady) begin
      @(negedge clk);
      driveControls();
      @(posedge clk);
    end
  endtask

  initial begin
    bundleT b;
    logic [15:0] same;
    logic [15:0] other;
    rst = 1'b1;
    flush = 1'b0;
    bundleValid = 1'b0;
    bundle = '0;
    resultAck = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    compareField("outputs", {1'b0, 1'b1, 93'b0},
                 {resultValid, bundleReady, retire, storeWrEn2, storeWrEn1, storeWrEn0});

    // slots 0..2 identical (2 invalid), slot 3 varies address and bank half
    testName = "conflict";
    for (int c = 0; c < 4; c++) begin
      for (int q = 0; q < 4; q++) begin
        b = '0;
        same = q[1] ? 16'h0003 : 16'h0002;
        other = q[1] ? 16'h0002 : 16'h0003;
        for (int s = 0; s < 4; s++) begin
          b.addrs[s].valid = (s != 2);
          b.addrs[s].oddHigh = (c == 0);
          b.addrs[s].oddLow = (c == 1);
          b.addrs[s].evenHigh = (c == 2);
          b.addrs[s].evenLow = (c == 3);
          b.addrs[s].evenAddr = (s == 3 && (q[0] ^ (c < 2))) ? 14'd6 : 14'd5;
          b.addrs[s].oddAddr = (s == 3 && (q[0] ^ (c >= 2))) ? 14'd10 : 14'd9;
          b.addrs[s].banks = 32'h0001_0001;
          b.slots[s].instrIdx = 4'(s);
        end
        b.addrs[3].banks = (c % 2 == 0) ? {same, other} : {other, same};
        b.wrInd0 = noStore;
        b.wrInd1 = noStore;
        b.wrInd2 = noStore;
        b.rotPos = 3'b001;
        sendBundle(b);
      end
    end

    testName = "store route";
    for (int r = 0; r < 3; r++) begin
      for (int v = 0; v < 7; v++) begin
        b = randBundle();
        b.rotPos = 3'(1 << r);
        b.wrInd0 = storeInd(v);
        b.wrInd1 = storeInd((v + 2) % 7);
        b.wrInd2 = storeInd((v + 5) % 7);
        sendBundle(b);
      end
    end

    testName = "random";
    ackMode = 1;
    randFlush = 1'b1;
    repeat (numRandom) begin
      sendBundle(randBundle());
      if (nextRand() % 4 == 0) begin
        idle();
      end
    end

    // hold a result, then flush it away
    testName = "flush";
    ackMode = 2;
    randFlush = 1'b0;
    @(negedge clk);
    flush = 1'b0;
    resultAck = 1'b1;
    bundleValid = 1'b0;
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    sendBundle(randBundle());
    idle();
    idle();
    @(negedge clk);
    flush = 1'b1;
    bundleValid = 1'b0;
    idle();
    ackMode = 0;
    sendBundle(randBundle());
    idle();
    while (expQ.size() != 0) begin
      idle();
    end
    idle();

    $display("errors: %0d mismatches, %0d other failures, %0d results checked",
             mismatchCount, otherCount, checkedCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
src/lsqPkg.sv
src/lsqConflictPair.sv
src/lsqConflictBundle.sv
src/storeWriteSelect.sv
src/lsqRetireDecide.sv
src/lsqCheckTop.sv
testbench/lsqCheckTb.sv

/* Bender.yml */
package:
  name: lsq_check

sources:
  - src/lsqPkg.sv
  - src/lsqConflictPair.sv
  - src/lsqConflictBundle.sv
  - src/storeWriteSelect.sv
  - src/lsqRetireDecide.sv
  - src/lsqCheckTop.sv
  - target: test
    files:
      - testbench/lsqCheckTb.sv
